// File: rtl/div_pkg.sv
`default_nettype none

package div_pkg;

    // operand and result width
    localparam int DATA_W = 16;

    // iteration counter must reach DATA_W
    localparam int CNT_W = 5;

    localparam int ADDR_W = 5;

    // register map, word offsets
    typedef enum logic [ADDR_W-1:0] {
        REG_CTRL     = 5'h00,
        REG_DIVIDEND = 5'h04,
        REG_DIVISOR  = 5'h08,
        REG_STATUS   = 5'h0C,
        REG_RESULT   = 5'h10
    } div_reg_e;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_RUN  = 1'b1
    } div_state_e;

endpackage

`default_nettype wire

// File: rtl/div_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module div_ctrl (
    input  wire logic CLK,
    input  wire logic RST,
    input  wire logic start,
    input  wire logic last,
    input  wire logic neg,
    output logic      load,
    output logic      iterate,
    output logic      restore,
    output logic      cnt_clear,
    output logic      cnt_en,
    output logic      ready
);

    import div_pkg::*;

    div_state_e state;
    div_state_e state_nxt;

    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    always_comb
    begin
        state_nxt = state;
        load      = 1'b0;
        iterate   = 1'b0;
        restore   = 1'b0;
        cnt_clear = 1'b0;
        cnt_en    = 1'b0;
        ready     = 1'b0;

        case (state)
            ST_IDLE:
            begin
                // load operands and restart the count
                if (start)
                begin
                    load      = 1'b1;
                    cnt_clear = 1'b1;
                    state_nxt = ST_RUN;
                end
            end
            ST_RUN:
            begin
                iterate = 1'b1;
                cnt_en  = 1'b1;
                // negative trial result means put A back
                restore = neg;
                if (last)
                begin
                    ready     = 1'b1;
                    state_nxt = ST_IDLE;
                end
            end
            default:
            begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/div_counter.sv
`timescale 1ns/1ns
`default_nettype none

module div_counter (
    input  wire logic CLK,
    input  wire logic RST,
    input  wire logic cnt_clear,
    input  wire logic cnt_en,
    output logic      last
);

    import div_pkg::*;

    logic [CNT_W-1:0] count;

    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
        begin
            count <= '0;
        end
        else if (cnt_clear)
        begin
            count <= '0;
        end
        else if (cnt_en)
        begin
            count <= count + 1'b1;
        end
    end

    // final iteration of the division
    assign last = (count == CNT_W'(DATA_W - 1));

endmodule

`default_nettype wire

// File: rtl/div_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module div_datapath (
    input  wire logic                         CLK,
    input  wire logic                         RST,
    input  wire logic                         load,
    input  wire logic                         iterate,
    input  wire logic                         restore,
    input  wire logic [div_pkg::DATA_W-1:0]   dividend,
    input  wire logic [div_pkg::DATA_W-1:0]   divisor,
    output logic                              neg,
    output logic      [div_pkg::DATA_W-1:0]   quotient,
    output logic      [div_pkg::DATA_W-1:0]   remainder
);

    import div_pkg::*;

    // partial remainder, divisor, dividend/quotient
    logic [DATA_W-1:0] a_reg;
    logic [DATA_W-1:0] m_reg;
    logic [DATA_W-1:0] q_reg;

    // A:Q shifted left by one, upper part
    logic [DATA_W:0]   a_shift;
    logic [DATA_W:0]   diff;
    logic [DATA_W-1:0] a_next;

    assign a_shift = {a_reg, q_reg[DATA_W-1]};

    // A < M holds between steps, so the sign fits in DATA_W+1 bits
    assign diff = a_shift - {1'b0, m_reg};
    assign neg  = diff[DATA_W];

    // restore mux
    assign a_next = restore ? a_shift[DATA_W-1:0] : diff[DATA_W-1:0];

    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
        begin
            a_reg <= '0;
            m_reg <= '0;
            q_reg <= '0;
        end
        else if (load)
        begin
            a_reg <= '0;
            m_reg <= divisor;
            q_reg <= dividend;
        end
        else if (iterate)
        begin
            a_reg <= a_next;
            // quotient bit is 1 when the subtraction stood
            q_reg <= {q_reg[DATA_W-2:0], ~restore};
        end
    end

    // zero divisor never restores: Q all ones, A ends as the dividend
    assign quotient  = q_reg;
    assign remainder = a_reg;

endmodule

`default_nettype wire

// File: rtl/div_apb_regs.sv
`timescale 1ns/1ns
`default_nettype none

module div_apb_regs (
    input  wire logic                         CLK,
    input  wire logic                         RST,
    input  wire logic                         psel,
    input  wire logic                         penable,
    input  wire logic                         pwrite,
    input  wire logic [div_pkg::ADDR_W-1:0]   paddr,
    input  wire logic [31:0]                  pwdata,
    output logic      [31:0]                  prdata,
    output logic                              pready,
    output logic                              pslverr,
    input  wire logic                         ready,
    input  wire logic [div_pkg::DATA_W-1:0]   quotient,
    input  wire logic [div_pkg::DATA_W-1:0]   remainder,
    output logic                              start,
    output logic      [div_pkg::DATA_W-1:0]   dividend,
    output logic      [div_pkg::DATA_W-1:0]   divisor
);

    import div_pkg::*;

    div_reg_e    reg_sel;
    logic        access;
    logic        addr_err;
    logic        wr_err;
    logic        err;
    logic        wr_ok;
    logic        busy;
    logic        done;
    logic [31:0] rdata;

    assign reg_sel = div_reg_e'(paddr);
    assign access  = psel & penable;

    // decode, read data and per-register write errors
    always_comb
    begin
        addr_err = 1'b0;
        wr_err   = 1'b0;
        rdata    = '0;
        case (reg_sel)
            REG_CTRL:
            begin
                wr_err = busy;
            end
            REG_DIVIDEND:
            begin
                rdata  = {{(32 - DATA_W){1'b0}}, dividend};
                wr_err = busy;
            end
            REG_DIVISOR:
            begin
                rdata  = {{(32 - DATA_W){1'b0}}, divisor};
                wr_err = busy;
            end
            REG_STATUS:
            begin
                rdata  = {30'b0, done, busy};
                wr_err = 1'b1;
            end
            REG_RESULT:
            begin
                rdata  = {remainder, quotient};
                wr_err = 1'b1;
            end
            default:
            begin
                addr_err = 1'b1;
            end
        endcase
    end

    assign err     = addr_err | (pwrite & wr_err);
    assign wr_ok   = access & pwrite & ~err;
    assign pslverr = access & err;
    assign pready  = 1'b1;
    assign prdata  = (access & ~pwrite) ? rdata : 32'b0;

    // busy already blocks the write through err
    assign start = wr_ok & (reg_sel == REG_CTRL) & pwdata[0];

    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
        begin
            dividend <= '0;
            divisor  <= '0;
        end
        else if (wr_ok)
        begin
            if (reg_sel == REG_DIVIDEND)
            begin
                dividend <= pwdata[DATA_W-1:0];
            end
            if (reg_sel == REG_DIVISOR)
            begin
                divisor <= pwdata[DATA_W-1:0];
            end
        end
    end

    // status flags
    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
        begin
            busy <= 1'b0;
            done <= 1'b0;
        end
        else if (start)
        begin
            busy <= 1'b1;
            done <= 1'b0;
        end
        else if (ready)
        begin
            busy <= 1'b0;
            done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/div_apb_top.sv
`timescale 1ns/1ns
`default_nettype none

module div_apb_top (
    input  wire logic                         CLK,
    input  wire logic                         RST,
    input  wire logic                         psel,
    input  wire logic                         penable,
    input  wire logic                         pwrite,
    input  wire logic [div_pkg::ADDR_W-1:0]   paddr,
    input  wire logic [31:0]                  pwdata,
    output logic      [31:0]                  prdata,
    output logic                              pready,
    output logic                              pslverr
);

    import div_pkg::*;

    logic              start;
    logic              load;
    logic              iterate;
    logic              restore;
    logic              cnt_clear;
    logic              cnt_en;
    logic              ready;
    logic              last;
    logic              neg;
    logic [DATA_W-1:0] dividend;
    logic [DATA_W-1:0] divisor;
    logic [DATA_W-1:0] quotient;
    logic [DATA_W-1:0] remainder;

    div_apb_regs regs_i (
        .CLK       (CLK),
        .RST       (RST),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .ready     (ready),
        .quotient  (quotient),
        .remainder (remainder),
        .start     (start),
        .dividend  (dividend),
        .divisor   (divisor)
    );

    div_ctrl ctrl_i (
        .CLK       (CLK),
        .RST       (RST),
        .start     (start),
        .last      (last),
        .neg       (neg),
        .load      (load),
        .iterate   (iterate),
        .restore   (restore),
        .cnt_clear (cnt_clear),
        .cnt_en    (cnt_en),
        .ready     (ready)
    );

    div_counter counter_i (
        .CLK       (CLK),
        .RST       (RST),
        .cnt_clear (cnt_clear),
        .cnt_en    (cnt_en),
        .last      (last)
    );

    div_datapath datapath_i (
        .CLK       (CLK),
        .RST       (RST),
        .load      (load),
        .iterate   (iterate),
        .restore   (restore),
        .dividend  (dividend),
        .divisor   (divisor),
        .neg       (neg),
        .quotient  (quotient),
        .remainder (remainder)
    );

endmodule

`default_nettype wire

// File: dv/tb_div_apb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_div_apb_top;

    import div_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RANDOM_RUNS = 250;
    // about 300 runs of 30 cycles each plus margin
    localparam int TIMEOUT_CYCLES = 10000;

    localparam logic [31:0] STAT_BUSY = 32'h1;
    localparam logic [31:0] STAT_DONE = 32'h2;

    logic              CLK;
    logic              RST;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;

    // {dividend, divisor} issued and RESULT words read back
    logic [31:0] operand_q[$];
    logic [31:0] result_q[$];
    int          cycle_cnt = 0;

    div_apb_top div_apb_top_i (
        .CLK     (CLK),
        .RST     (RST),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial
    begin
        CLK = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) CLK = ~CLK;
        end
    end

    always @(posedge CLK)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    end

    // quotient in the low half and remainder in the high half
    function automatic logic [31:0] expected_result(input logic [DATA_W-1:0] dvd,
                                                     input logic [DATA_W-1:0] dvs);
        logic [DATA_W-1:0] q;
        logic [DATA_W-1:0] r;
        // zero divisor gives all ones and the dividend
        if (dvs == '0)
        begin
            q = '1;
            r = dvd;
        end
        else
        begin
            q = dvd / dvs;
            r = dvd % dvs;
        end
        return {r, q};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERROR: %s is 0x%h, expected 0x%h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // called DRIVE_DELAY after a rising edge, returns the same way
    task automatic apb_transfer(input logic wr, input logic [ADDR_W-1:0] addr,
                                input logic [31:0] wdata, input logic exp_err,
                                output logic [31:0] rdata);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge CLK);
        #DRIVE_DELAY;
        penable = 1'b1;
        @(negedge CLK);
        rdata = prdata;
        check_value("pready", {31'b0, pready}, 32'h1);
        check_value("pslverr", {31'b0, pslverr}, {31'b0, exp_err});
        @(posedge CLK);
        #DRIVE_DELAY;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, exp_err, unused);
    endtask

    task automatic read_expect(input string name, input logic [ADDR_W-1:0] addr,
                               input logic [31:0] exp);
        logic [31:0] data;
        apb_transfer(1'b0, addr, 32'h0, 1'b0, data);
        check_value(name, data, exp);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        status = '0;
        while (status !== STAT_DONE)
        begin
            apb_transfer(1'b0, REG_STATUS, 32'h0, 1'b0, status);
            if (status !== STAT_DONE)
            begin
                check_value("prdata STATUS", status, STAT_BUSY);
            end
        end
    endtask

    task automatic collect_result(input logic [DATA_W-1:0] dvd, input logic [DATA_W-1:0] dvs);
        logic [31:0] result;
        apb_transfer(1'b0, REG_RESULT, 32'h0, 1'b0, result);
        operand_q.push_back({dvd, dvs});
        result_q.push_back(result);
    endtask

    task automatic run_division(input logic [DATA_W-1:0] dvd, input logic [DATA_W-1:0] dvs);
        write_reg(REG_DIVIDEND, 32'(dvd), 1'b0);
        write_reg(REG_DIVISOR, 32'(dvs), 1'b0);
        read_expect("prdata DIVIDEND", REG_DIVIDEND, 32'(dvd));
        read_expect("prdata DIVISOR", REG_DIVISOR, 32'(dvs));
        write_reg(REG_CTRL, 32'h1, 1'b0);
        read_expect("prdata STATUS", REG_STATUS, STAT_BUSY);
        wait_done();
        collect_result(dvd, dvs);
    endtask

    // status read whose access phase ends n+2 edges after the start edge
    task automatic check_latency(input int n, input logic [31:0] exp_status);
        write_reg(REG_CTRL, 32'h1, 1'b0);
        repeat (n) @(posedge CLK);
        #DRIVE_DELAY;
        read_expect("prdata STATUS", REG_STATUS, exp_status);
        wait_done();
        collect_result(16'd1000, 16'd3);
    endtask

    always @(posedge CLK)
    begin : compare_results
        logic [31:0] operands;
        logic [31:0] got;
        if (result_q.size() > 0 && operand_q.size() > 0)
        begin
            operands = operand_q.pop_front();
            got      = result_q.pop_front();
            check_value("prdata RESULT", got, expected_result(operands[31:16], operands[15:0]));
        end
    end

    initial
    begin : stimulus
        int unsigned       seed_init;
        logic [DATA_W-1:0] dvd;
        logic [DATA_W-1:0] dvs;
        RST     = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        seed_init = $urandom(23827);
        repeat (5) @(posedge CLK);
        #DRIVE_DELAY;
        RST = 1'b1;

        read_expect("prdata STATUS", REG_STATUS, 32'h0);
        read_expect("prdata DIVIDEND", REG_DIVIDEND, 32'h0);
        read_expect("prdata DIVISOR", REG_DIVISOR, 32'h0);
        read_expect("prdata RESULT", REG_RESULT, 32'h0);

        run_division(16'd100, 16'd7);
        run_division(16'hFFFF, 16'd1);
        run_division(16'd5, 16'd9);
        run_division(16'd1234, 16'd1234);
        run_division(16'hFFFF, 16'hFFFF);

        for (int i = 0; i < RANDOM_RUNS; i++)
        begin
            dvd = $urandom_range(16'hFFFF, 1);
            // spread the divisor over all magnitudes
            dvs = $urandom_range(16'hFFFF, 1) >> $urandom_range(15, 0);
            if (dvs == '0)
            begin
                dvs = 16'd1;
            end
            run_division(dvd, dvs);
        end

        run_division(16'd12345, 16'd0);
        run_division(16'd0, 16'd0);

        // operand and start writes rejected while busy
        write_reg(REG_DIVIDEND, 32'd1000, 1'b0);
        write_reg(REG_DIVISOR, 32'd3, 1'b0);
        write_reg(REG_CTRL, 32'h1, 1'b0);
        write_reg(REG_DIVIDEND, 32'd5, 1'b1);
        write_reg(REG_DIVISOR, 32'd5, 1'b1);
        write_reg(REG_CTRL, 32'h1, 1'b1);
        read_expect("prdata DIVIDEND", REG_DIVIDEND, 32'd1000);
        read_expect("prdata DIVISOR", REG_DIVISOR, 32'd3);
        wait_done();
        collect_result(16'd1000, 16'd3);

        write_reg(REG_STATUS, 32'h3, 1'b1);
        write_reg(REG_RESULT, 32'h0, 1'b1);
        write_reg(5'h14, 32'h1, 1'b1);
        write_reg(5'h02, 32'h1, 1'b1);
        read_expect("prdata STATUS", REG_STATUS, STAT_DONE);
        read_expect("prdata DIVIDEND", REG_DIVIDEND, 32'd1000);

        check_latency(14, STAT_BUSY);
        check_latency(15, STAT_DONE);

        while (result_q.size() != 0)
        begin
            @(posedge CLK);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: div_apb_top.f
rtl/div_pkg.sv
rtl/div_ctrl.sv
rtl/div_counter.sv
rtl/div_datapath.sv
rtl/div_apb_regs.sv
rtl/div_apb_top.sv
dv/tb_div_apb_top.sv

// File: Bender.yml
package:
  name: div_apb

sources:
  - rtl/div_pkg.sv
  - rtl/div_ctrl.sv
  - rtl/div_counter.sv
  - rtl/div_datapath.sv
  - rtl/div_apb_regs.sv
  - rtl/div_apb_top.sv
  - target: test
    files:
      - dv/tb_div_apb_top.sv
